// ==== verilog/vision_pkg.sv ====
package vision_pkg;

   //////////////////////////////////////////////////
   // camera side

   typedef struct packed {
      logic       pclk;                 // pixel clock returned by the camera
      logic       vsync;
      logic       href;                 // line valid
      logic [7:0] data;
   } cam_bus_t;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb444_t;

   //////////////////////////////////////////////////
   // display side

   typedef struct packed {
      logic [10:0] hcount;              // pixel on current line
      logic [9:0]  vcount;              // line number
      logic        hsync;               // active high in here
      logic        vsync;
      logic        blank;
   } video_timing_t;

   typedef enum logic [2:0] {
      FILTER_PASS,
      FILTER_DIFF,
      FILTER_RED,
      FILTER_GREEN,
      FILTER_BLUE
   } filter_mode_e;

   typedef enum logic [1:0] {
      DISP_CAMERA  = 2'b00,
      DISP_OUTLINE = 2'b01,
      DISP_BARS    = 2'b10              // 11 falls back to camera
   } display_mode_e;

   typedef struct packed {
      display_mode_e disp_mode;
      logic          zoom;              // 2x pixel doubling
      logic          diff_en;
      logic          red_en;
      logic          green_en;
      logic          blue_en;
   } mode_switches_t;

   localparam logic [3:0] key_threshold = 4'd8;  // mid scale on 4-bit channel

endpackage

// ==== verilog/camera_capture.sv ====
`timescale 1ns/10ps

module camera_capture import vision_pkg::*; (
   input  logic     clk_65mhz,
   input  logic     reset_in,
   input  cam_bus_t cam,
   output logic     cam_xclk,           // clk / 4 back to the camera
   output rgb565_t  pixel,
   output logic     pixel_valid,        // one-cycle strobe
   output logic     frame_done          // rising edge of synced vsync
);

   logic [1:0] xclk_count;
   cam_bus_t   cam_sync1, cam_sync2;     // two-flop synchroniser
   logic       pclk_prev, vsync_prev;
   logic       pclk_rise;
   logic       high_next;                // byte phase, 1 = high byte expected
   logic [7:0] high_byte;

   assign cam_xclk  = (xclk_count > 2'b01);             // 50% duty
   assign pclk_rise = cam_sync2.pclk & ~pclk_prev;

   //////////////////////////////////////////////////
   // clock divider and bus sync
   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         xclk_count <= 2'b00;
         cam_sync1  <= '0;
         cam_sync2  <= '0;
         pclk_prev  <= 1'b0;
         vsync_prev <= 1'b0;
      end else begin
         xclk_count <= xclk_count + 2'b01;
         cam_sync1  <= cam;
         cam_sync2  <= cam_sync1;
         pclk_prev  <= cam_sync2.pclk;   // edge detect history
         vsync_prev <= cam_sync2.vsync;
      end
   end

   //////////////////////////////////////////////////
   // byte pair assembly
   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         high_next   <= 1'b1;
         pixel_valid <= 1'b0;
         frame_done  <= 1'b0;
      end else begin
         pixel_valid <= 1'b0;
         frame_done  <= cam_sync2.vsync & ~vsync_prev;
         if (cam_sync2.vsync) begin
            high_next <= 1'b1;            // realign phase every frame
         end else if (pclk_rise && cam_sync2.href) begin
            if (high_next) begin
               high_byte <= cam_sync2.data;
               high_next <= 1'b0;
            end else begin
               pixel       <= {high_byte, cam_sync2.data};  // rrrrrggg gggbbbbb
               pixel_valid <= 1'b1;
               high_next   <= 1'b1;
            end
         end
      end
   end

   // two bytes per pixel, so strobes never touch
   a_valid_gap: assert property (@(posedge clk_65mhz) disable iff (reset_in)
      pixel_valid |=> !pixel_valid);

   a_done_not_valid: assert property (@(posedge clk_65mhz) disable iff (reset_in)
      !(frame_done && pixel_valid));

endmodule

// ==== verilog/pixel_filter.sv ====
`timescale 1ns/10ps

module pixel_filter import vision_pkg::*; (
   input  logic           clk_65mhz,
   input  logic           reset_in,
   input  rgb565_t        pixel,
   input  logic           pixel_valid,
   input  mode_switches_t switches,
   output rgb444_t        filtered,
   output logic           wr_valid    // pixel_valid delayed by one
);

   filter_mode_e mode;
   rgb444_t      cur;                   // truncated incoming pixel
   rgb444_t      prev;                  // last valid pixel in diff mode

   function automatic logic [3:0] abs_diff(input logic [3:0] a, input logic [3:0] b);
      return (a > b) ? a - b : b - a;
   endfunction

   assign cur = '{r: pixel.r[4:1], g: pixel.g[5:2], b: pixel.b[4:1]};  // top 4 bits

   // switch priority: diff > red > green > blue
   always_comb begin
      if (switches.diff_en)       mode = FILTER_DIFF;
      else if (switches.red_en)   mode = FILTER_RED;
      else if (switches.green_en) mode = FILTER_GREEN;
      else if (switches.blue_en)  mode = FILTER_BLUE;
      else                        mode = FILTER_PASS;
   end

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         wr_valid <= 1'b0;
         prev     <= '0;
      end else begin
         wr_valid <= pixel_valid;
         if (mode != FILTER_DIFF) prev <= '0;   // new diff run starts from black
         else if (pixel_valid)    prev <= cur;
      end
   end

   always_ff @(posedge clk_65mhz) begin
      filtered <= '0;                   // key miss -> black
      case (mode)
         FILTER_DIFF: filtered <= '{r: abs_diff(cur.r, prev.r),
                                    g: abs_diff(cur.g, prev.g),
                                    b: abs_diff(cur.b, prev.b)};
         FILTER_RED:   if (cur.r > key_threshold && cur.g < key_threshold &&
                           cur.b < key_threshold) filtered <= 12'hf00;
         FILTER_GREEN: if (cur.r < key_threshold && cur.g > key_threshold &&
                           cur.b < key_threshold) filtered <= 12'h0f0;
         FILTER_BLUE:  if (cur.r < key_threshold && cur.g < key_threshold &&
                           cur.b > key_threshold) filtered <= 12'h00f;
         default:     filtered <= cur;  // pass
      endcase
   end

endmodule

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer import vision_pkg::*; #(
   parameter int FB_WIDTH  = 320,
   parameter int FB_HEIGHT = 240
) (
   input  logic                                   clk_65mhz,
   input  logic                                   reset_in,
   input  rgb444_t                                wr_data,
   input  logic                                   wr_valid,
   input  logic                                   frame_done,
   input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] rd_addr,
   output rgb444_t                                rd_data
);

   localparam int DEPTH  = FB_WIDTH * FB_HEIGHT;
   localparam int ADDR_W = $clog2(DEPTH);

   rgb444_t     mem [DEPTH];
   logic [ADDR_W:0] wr_addr;            // one spare bit, parks at DEPTH
   logic        wr_in_range;

   assign wr_in_range = (wr_addr < (ADDR_W+1)'(DEPTH));

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) wr_addr <= '0;
      else if (frame_done) wr_addr <= '0;               // restart each frame
      else if (wr_valid && wr_in_range) wr_addr <= wr_addr + 1'b1;
   end

   // inferred ram, registered read
   always_ff @(posedge clk_65mhz) begin
      if (wr_valid && wr_in_range) mem[wr_addr[ADDR_W-1:0]] <= wr_data;
      rd_data <= mem[rd_addr];
   end

   // compositor must clamp its address outside the camera window
   a_rd_addr_range: assert property (@(posedge clk_65mhz) disable iff (reset_in)
      rd_addr < ADDR_W'(DEPTH));

endmodule

// ==== verilog/video_timing.sv ====
`timescale 1ns/10ps

module video_timing import vision_pkg::*; #(
   parameter int DISPLAY_WIDTH  = 1024,
   parameter int DISPLAY_HEIGHT = 768,
   parameter int H_FP           = 24,
   parameter int H_SYNC_PULSE   = 136,
   parameter int H_BP           = 160,
   parameter int V_FP           = 3,
   parameter int V_SYNC_PULSE   = 6,
   parameter int V_BP           = 29
) (
   input  logic          clk_65mhz,
   input  logic          reset_in,
   output video_timing_t timing         // all fields registered
);

   localparam int H_TOTAL = DISPLAY_WIDTH + H_FP + H_SYNC_PULSE + H_BP;
   localparam int V_TOTAL = DISPLAY_HEIGHT + V_FP + V_SYNC_PULSE + V_BP;

   logic hblank, vblank;
   logic hblankon, hsyncon, hsyncoff, hreset;
   logic vblankon, vsyncon, vsyncoff, vreset;
   logic next_hblank, next_vblank;

   //////////////////////////////////////////////////
   // events, one cycle before the change
   assign hblankon = (timing.hcount == 11'(DISPLAY_WIDTH - 1));
   assign hsyncon  = (timing.hcount == 11'(DISPLAY_WIDTH + H_FP - 1));
   assign hsyncoff = (timing.hcount == 11'(DISPLAY_WIDTH + H_FP + H_SYNC_PULSE - 1));
   assign hreset   = (timing.hcount == 11'(H_TOTAL - 1));   // end of line

   assign vblankon = hreset & (timing.vcount == 10'(DISPLAY_HEIGHT - 1));
   assign vsyncon  = hreset & (timing.vcount == 10'(DISPLAY_HEIGHT + V_FP - 1));
   assign vsyncoff = hreset & (timing.vcount == 10'(DISPLAY_HEIGHT + V_FP + V_SYNC_PULSE - 1));
   assign vreset   = hreset & (timing.vcount == 10'(V_TOTAL - 1));

   assign next_hblank = hreset ? 1'b0 : (hblankon ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblankon ? 1'b1 : vblank);

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         timing <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
      end else begin
         timing.hcount <= hreset ? 11'd0 : timing.hcount + 11'd1;
         if (hreset) timing.vcount <= vreset ? 10'd0 : timing.vcount + 10'd1;
         hblank <= next_hblank;
         vblank <= next_vblank;
         // set/clear, active high
         timing.hsync <= hsyncon ? 1'b1 : (hsyncoff ? 1'b0 : timing.hsync);
         timing.vsync <= vsyncon ? 1'b1 : (vsyncoff ? 1'b0 : timing.vsync);
         timing.blank <= next_vblank | next_hblank;
      end
   end

   a_hcount_range: assert property (@(posedge clk_65mhz) disable iff (reset_in)
      timing.hcount < 11'(H_TOTAL));

endmodule

// ==== verilog/display_compositor.sv ====
`timescale 1ns/10ps

module display_compositor import vision_pkg::*; #(
   parameter int DISPLAY_WIDTH  = 1024,
   parameter int DISPLAY_HEIGHT = 768,
   parameter int FB_WIDTH       = 320,
   parameter int FB_HEIGHT      = 240
) (
   input  logic                                   clk_65mhz,
   input  logic                                   reset_in,
   input  video_timing_t                          timing,
   input  mode_switches_t                         switches,
   input  rgb444_t                                rd_data,
   output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] rd_addr,
   output logic [3:0]                             vga_r,
   output logic [3:0]                             vga_g,
   output logic [3:0]                             vga_b,
   output logic                                   vga_hs,
   output logic                                   vga_vs
);

   localparam int ADDR_W = $clog2(FB_WIDTH * FB_HEIGHT);

   logic [10:0]   xs;
   logic [9:0]    ys;
   logic          in_window, border;
   video_timing_t timing_d1, timing_d2;  // matches ram read latency
   logic          use_cam_d1, in_win_d1;
   rgb444_t       pat_d1, rgb_d2;

   //////////////////////////////////////////////////
   // read address, zoom halves both counts
   assign xs = switches.zoom ? (timing.hcount >> 1) : timing.hcount;
   assign ys = switches.zoom ? (timing.vcount >> 1) : timing.vcount;
   assign in_window = switches.zoom ?
      (timing.hcount < 11'(2*FB_WIDTH) && timing.vcount < 10'(2*FB_HEIGHT)) :
      (timing.hcount < 11'(FB_WIDTH)   && timing.vcount < 10'(FB_HEIGHT));
   assign rd_addr = in_window ? ADDR_W'(32'(ys) * FB_WIDTH + 32'(xs)) : '0;  // clamp

   assign border = (timing.hcount == 11'd0) || (timing.hcount == 11'(DISPLAY_WIDTH - 1)) ||
                   (timing.hcount == 11'(DISPLAY_WIDTH / 2)) || (timing.vcount == 10'd0) ||
                   (timing.vcount == 10'(DISPLAY_HEIGHT - 1)) ||
                   (timing.vcount == 10'(DISPLAY_HEIGHT / 2));

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         timing_d1 <= '0;
         timing_d2 <= '0;
         rgb_d2    <= '0;
      end else begin
         timing_d1 <= timing;             // stage 1, ram busy reading
         in_win_d1 <= in_window;
         use_cam_d1 <= 1'b0;
         case (switches.disp_mode)
            DISP_OUTLINE: pat_d1 <= {12{border}};
            DISP_BARS:    pat_d1 <= {{4{timing.hcount[8]}}, {4{timing.hcount[7]}},
                                     {4{timing.hcount[6]}}};
            default: begin
               pat_d1     <= '0;
               use_cam_d1 <= 1'b1;
            end
         endcase
         timing_d2 <= timing_d1;          // stage 2, pick colour
         rgb_d2    <= use_cam_d1 ? (in_win_d1 ? rd_data : '0) : pat_d1;
      end
   end

   // pins, syncs go active low here
   assign vga_r  = timing_d2.blank ? 4'h0 : rgb_d2.r;
   assign vga_g  = timing_d2.blank ? 4'h0 : rgb_d2.g;
   assign vga_b  = timing_d2.blank ? 4'h0 : rgb_d2.b;
   assign vga_hs = ~timing_d2.hsync;
   assign vga_vs = ~timing_d2.vsync;

endmodule

// ==== verilog/camera_video_top.sv ====
`timescale 1ns/10ps

module camera_video_top import vision_pkg::*; #(
   parameter int DISPLAY_WIDTH  = 1024,
   parameter int DISPLAY_HEIGHT = 768,
   parameter int H_FP           = 24,
   parameter int H_SYNC_PULSE   = 136,
   parameter int H_BP           = 160,
   parameter int V_FP           = 3,
   parameter int V_SYNC_PULSE   = 6,
   parameter int V_BP           = 29,
   parameter int FB_WIDTH       = 320,
   parameter int FB_HEIGHT      = 240
) (
   input  logic           clk_65mhz,
   input  logic           reset_in,
   input  cam_bus_t       cam,
   input  mode_switches_t switches,
   output logic           cam_xclk,
   output logic [3:0]     vga_r,
   output logic [3:0]     vga_g,
   output logic [3:0]     vga_b,
   output logic           vga_hs,
   output logic           vga_vs
);

   rgb565_t       pixel;
   logic          pixel_valid, frame_done, wr_valid;
   rgb444_t       filtered, rd_data;
   video_timing_t timing;
   logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] rd_addr;

   camera_capture u_capture (.clk_65mhz, .reset_in, .cam, .cam_xclk, .pixel,
                             .pixel_valid, .frame_done);

   pixel_filter u_filter (.clk_65mhz, .reset_in, .pixel, .pixel_valid, .switches,
                          .filtered, .wr_valid);

   frame_buffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_fb (
      .clk_65mhz, .reset_in, .wr_data(filtered), .wr_valid, .frame_done, .rd_addr, .rd_data);

   video_timing #(.DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
                  .H_FP(H_FP), .H_SYNC_PULSE(H_SYNC_PULSE), .H_BP(H_BP),
                  .V_FP(V_FP), .V_SYNC_PULSE(V_SYNC_PULSE), .V_BP(V_BP)) u_timing (
      .clk_65mhz, .reset_in, .timing);

   display_compositor #(.DISPLAY_WIDTH(DISPLAY_WIDTH), .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
                        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_comp (
      .clk_65mhz, .reset_in, .timing, .switches, .rd_data, .rd_addr,
      .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs);

endmodule

// ==== verification/tb_camera_video.sv ====
`timescale 1ns/10ps

module tb_camera_video import vision_pkg::*; ();

   localparam int DISP_W  = 32;
   localparam int DISP_H  = 24;
   localparam int HFP     = 2;
   localparam int HSP     = 4;
   localparam int HBP     = 3;
   localparam int VFP     = 1;
   localparam int VSP     = 2;
   localparam int VBP     = 2;
   localparam int FB_W    = 16;
   localparam int FB_H    = 12;
   localparam int FB_AW   = $clog2(FB_W * FB_H);
   localparam int H_TOTAL = DISP_W + HFP + HSP + HBP;
   localparam int FRAME_CYCLES = H_TOTAL * (DISP_H + VFP + VSP + VBP);
   localparam logic [3:0] KEY_LEVEL = 4'd8;

   logic           clk_65mhz;
   logic           reset_in;
   cam_bus_t       cam;
   mode_switches_t switches;
   logic           cam_xclk;
   logic [3:0]     vga_r;
   logic [3:0]     vga_g;
   logic [3:0]     vga_b;
   logic           vga_hs;
   logic           vga_vs;

   rgb444_t expect_fb [FB_W*FB_H];      // expected ram image, filled while sending
   rgb444_t diff_prev;                  // history for difference mode
   int      errors;
   int      pixel_checks;
   int      sync_checks;
   int      xclk_checks;
   int      frame_count;                // rising edges seen on vga_vs
   logic    check_en;
   logic    timed_out;

   // checker state
   logic    hs_prev, vs_prev, synced;
   int      col, row, hs_low, vs_low;
   logic    xclk_prev, xclk_seen;
   int      xclk_run;                   // cycles at the current cam_xclk level

   camera_video_top #(.DISPLAY_WIDTH(DISP_W), .DISPLAY_HEIGHT(DISP_H), .H_FP(HFP),
                      .H_SYNC_PULSE(HSP), .H_BP(HBP), .V_FP(VFP), .V_SYNC_PULSE(VSP),
                      .V_BP(VBP), .FB_WIDTH(FB_W), .FB_HEIGHT(FB_H)) u_dut (
      .clk_65mhz, .reset_in, .cam, .switches, .cam_xclk,
      .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs);

   initial clk_65mhz = 1'b0;
   always #20 clk_65mhz = ~clk_65mhz;   // 40 ns period

   //////////////////////////////////////////////////
   // reference model

   function automatic rgb444_t truncate_ref(input logic [15:0] p);
      rgb444_t t;
      t.r = p[15:12];                   // top of 5-bit red
      t.g = p[10:7];                    // top of 6-bit green
      t.b = p[4:1];
      return t;
   endfunction

   function automatic logic [3:0] abs4(input logic [3:0] a, input logic [3:0] b);
      return (a > b) ? a - b : b - a;
   endfunction

   function automatic rgb444_t filter_ref(input mode_switches_t sw, input logic [15:0] p,
                                          input rgb444_t prev);
      rgb444_t c;
      rgb444_t o;
      c = truncate_ref(p);
      o = 12'h000;                      // key miss
      if (sw.diff_en) begin
         o.r = abs4(c.r, prev.r);
         o.g = abs4(c.g, prev.g);
         o.b = abs4(c.b, prev.b);
      end else if (sw.red_en) begin
         if (c.r > KEY_LEVEL && c.g < KEY_LEVEL && c.b < KEY_LEVEL) o = 12'hf00;
      end else if (sw.green_en) begin
         if (c.r < KEY_LEVEL && c.g > KEY_LEVEL && c.b < KEY_LEVEL) o = 12'h0f0;
      end else if (sw.blue_en) begin
         if (c.r < KEY_LEVEL && c.g < KEY_LEVEL && c.b > KEY_LEVEL) o = 12'h00f;
      end else begin
         o = c;
      end
      return o;
   endfunction

   // colour of active pixel x,y
   function automatic rgb444_t pattern_ref(input mode_switches_t sw, input int x, input int y);
      logic [10:0] h;
      logic        on_grid;
      h = 11'(x);
      on_grid = (x == 0) || (x == DISP_W - 1) || (x == DISP_W / 2) ||
                (y == 0) || (y == DISP_H - 1) || (y == DISP_H / 2);
      case (sw.disp_mode)
         DISP_OUTLINE: return on_grid ? 12'hfff : 12'h000;
         DISP_BARS:    return {{4{h[8]}}, {4{h[7]}}, {4{h[6]}}};
         default: begin
            if (sw.zoom && x < 2*FB_W && y < 2*FB_H)
               return expect_fb[FB_AW'((y/2)*FB_W + x/2)];   // 2x2 blocks
            else if (!sw.zoom && x < FB_W && y < FB_H)
               return expect_fb[FB_AW'(y*FB_W + x)];
            else
               return 12'h000;          // outside camera window
         end
      endcase
   endfunction

   function automatic mode_switches_t make_switches(input display_mode_e d, input logic z,
                                                    input logic [3:0] filt);
      mode_switches_t s;
      s.disp_mode = d;
      s.zoom      = z;
      {s.diff_en, s.red_en, s.green_en, s.blue_en} = filt;
      return s;
   endfunction

   //////////////////////////////////////////////////
   // checker, samples on the falling edge

   always @(negedge clk_65mhz) begin
      logic [11:0] got;
      rgb444_t     exp_px;
      int          x;
      int          y;
      if (reset_in) begin
         synced  = 1'b0;
         hs_prev = 1'b1;
         vs_prev = 1'b1;
         col     = 0;
         row     = 0;
         hs_low  = 0;
         vs_low  = 0;
      end else begin
         if (!vga_hs) hs_low++;
         if (!vga_vs) vs_low++;
         if (vga_hs && !hs_prev) begin  // end of hsync, next line begins
            if (synced && (hs_low != HSP || col != H_TOTAL - 1)) begin
               errors++;
               $display("ERROR vga_hs low 'h%0h cycles period 'h%0h, expected 'h%0h and 'h%0h",
                        hs_low, col + 1, HSP, H_TOTAL);
            end
            if (synced) sync_checks++;
            col    = 0;
            row++;
            hs_low = 0;
         end else begin
            col++;
         end
         if (vga_vs && !vs_prev) begin
            if (synced && vs_low != VSP * H_TOTAL) begin
               errors++;
               $display("ERROR vga_vs low 'h%0h cycles, expected 'h%0h", vs_low, VSP * H_TOTAL);
            end
            if (synced) sync_checks++;
            vs_low = 0;
            row    = -VBP;              // back porch lines before line 0
            synced = 1'b1;
            frame_count++;
         end
         x = col - HBP;
         y = row;
         if (synced && check_en) begin
            got    = {vga_r, vga_g, vga_b};
            exp_px = (x >= 0 && x < DISP_W && y >= 0 && y < DISP_H) ?
                     pattern_ref(switches, x, y) : 12'h000;
            if (got !== exp_px) begin
               errors++;
               $display("ERROR {vga_r,vga_g,vga_b} x=%0d y=%0d got %h expected %h",
                        x, y, got, exp_px);
            end
            pixel_checks++;
         end
         hs_prev = vga_hs;
         vs_prev = vga_vs;
      end
   end

   // cam_xclk is clk / 4, so each level lasts two cycles
   always @(negedge clk_65mhz) begin
      if (reset_in) begin
         xclk_seen = 1'b0;
         xclk_run  = 0;
      end else if (cam_xclk !== xclk_prev) begin
         if (xclk_seen && xclk_run != 2) begin
            errors++;
            $display("ERROR cam_xclk level held 'h%0h cycles, expected 'h%0h", xclk_run, 2);
         end
         if (xclk_seen) xclk_checks++;
         xclk_seen = 1'b1;              // first edge after reset only starts a run
         xclk_run  = 1;
      end else begin
         xclk_run++;
      end
      xclk_prev = cam_xclk;
   end

   //////////////////////////////////////////////////
   // stimulus tasks

   task automatic wait_frame_start();
      int start;
      int cycles;
      start  = frame_count;
      cycles = 0;
      while (frame_count == start && cycles < 2 * FRAME_CYCLES && !timed_out) begin
         @(posedge clk_65mhz);
         cycles++;
      end
      if (frame_count == start && !timed_out) begin
         timed_out = 1'b1;             // later waits fall through
         errors++;
         $display("timeout, no rising edge on vga_vs within %0d cycles", 2 * FRAME_CYCLES);
      end
   endtask

   task automatic check_frame();
      wait_frame_start();
      check_en = 1'b1;
      wait_frame_start();
      check_en = 1'b0;
   endtask

   task automatic send_byte(input logic [7:0] b);
      cam.href <= 1'b1;
      cam.data <= b;
      cam.pclk <= 1'b0;
      repeat (4) @(posedge clk_65mhz);
      cam.pclk <= 1'b1;                 // camera data valid at this edge
      repeat (4) @(posedge clk_65mhz);
   endtask

   task automatic send_frame(input mode_switches_t sw);
      logic [15:0] p;
      @(posedge clk_65mhz);
      cam.vsync <= 1'b1;                // restarts write address and byte phase
      repeat (8) @(posedge clk_65mhz);
      cam.vsync <= 1'b0;
      repeat (8) @(posedge clk_65mhz);
      for (int y = 0; y < FB_H; y++) begin
         for (int x = 0; x < FB_W; x++) begin
            p = 16'($urandom);
            expect_fb[FB_AW'(y*FB_W + x)] = filter_ref(sw, p, diff_prev);
            diff_prev = sw.diff_en ? truncate_ref(p) : 12'h000;
            send_byte(p[15:8]);
            send_byte(p[7:0]);
         end
         cam.href <= 1'b0;              // line gap
         repeat (8) @(posedge clk_65mhz);
      end
   endtask

   task automatic camera_test(input mode_switches_t sw);
      switches <= sw;
      send_frame(sw);
      wait_frame_start();               // one full display frame first
      check_frame();
   endtask

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      void'($urandom(67));
      reset_in     = 1'b1;
      cam          = '0;
      switches     = make_switches(DISP_OUTLINE, 1'b0, 4'b0000);
      diff_prev    = 12'h000;
      errors       = 0;
      pixel_checks = 0;
      sync_checks  = 0;
      xclk_checks  = 0;
      frame_count  = 0;
      check_en     = 1'b0;
      timed_out    = 1'b0;
      repeat (8) @(posedge clk_65mhz);
      reset_in <= 1'b0;

      check_frame();                    // outline grid plus sync widths
      switches <= make_switches(DISP_BARS, 1'b0, 4'b0000);
      check_frame();
      camera_test(make_switches(DISP_CAMERA, 1'b0, 4'b0000));  // pass-through
      switches <= make_switches(DISP_CAMERA, 1'b1, 4'b0000);  // same image zoomed
      check_frame();
      camera_test(make_switches(DISP_CAMERA, 1'b0, 4'b0100));  // red key
      camera_test(make_switches(DISP_CAMERA, 1'b0, 4'b0010));  // green key
      camera_test(make_switches(DISP_CAMERA, 1'b0, 4'b0001));  // blue key
      camera_test(make_switches(DISP_CAMERA, 1'b0, 4'b1000));  // difference

      if (pixel_checks == 0) begin
         errors++;
         $display("no pixel was compared against the reference");
      end
      if (xclk_checks == 0) begin
         errors++;
         $display("cam_xclk never toggled after reset");
      end
      $display("pixel checks %0d, sync checks %0d, xclk checks %0d, errors %0d",
               pixel_checks, sync_checks, xclk_checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
verilog/vision_pkg.sv
verilog/camera_capture.sv
verilog/pixel_filter.sv
verilog/frame_buffer.sv
verilog/video_timing.sv
verilog/display_compositor.sv
verilog/camera_video_top.sv
verification/tb_camera_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the camera video testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="all tests passed"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_camera_video -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_camera_video > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# verdict comes from the log only
if grep -q "^${PASS_MSG}\$" "$LOG"; then
   exit 0
fi
exit 1
